//--- Bender.yml
package:
  name: sa_matvec

sources:
  # Packages first, then cells and stages, then the top level.
  - files:
      - src/sa_cfg_pkg.sv
      - src/sa_bus_pkg.sv
      - src/sa_pe.sv
      - src/sa_array.sv
      - src/sa_weight_loader.sv
      - src/sa_skew.sv
      - src/sa_deskew.sv
      - src/sa_top.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/sa_tb.sv

//--- flist.f
+incdir+sim
src/sa_cfg_pkg.sv
src/sa_bus_pkg.sv
src/sa_pe.sv
src/sa_array.sv
src/sa_weight_loader.sv
src/sa_skew.sv
src/sa_deskew.sv
src/sa_top.sv
sim/sa_tb.sv

//--- sim/sa_model.svh
`ifndef SA_MODEL_SVH
`define SA_MODEL_SVH

// Matrix currently held by the grid, as the testbench believes it.
weight_mat_t model_w = '0;

// Expected sum vectors, oldest first.
sum_vec_t exp_q [$];

// Column j is the sum over rows i of act[i] * W[i][j].
function automatic sum_vec_t expected_sums(input act_vec_t a, input weight_mat_t w);
	sum_vec_t    s;
	int unsigned col_sum;
	s = '0;
	for (int j = 0; j < array_dim; j++) begin
		col_sum = 0;
		for (int i = 0; i < array_dim; i++) begin
			col_sum = col_sum + int'(a[i]) * int'(w[i][j]);
		end
		s[j] = acc_t'(col_sum);
	end
	return s;
endfunction

task automatic model_set_matrix(input weight_mat_t w);
	model_w = w;
endtask

task automatic model_push(input act_vec_t a);
	exp_q.push_back(expected_sums(a, model_w)); // Uses the matrix in force now.
endtask

function automatic int model_pending();
	return exp_q.size();
endfunction

`endif

//--- sim/sa_tb.sv
`timescale 1ns/1ps

module sa_tb;

	import sa_cfg_pkg::*;
	import sa_bus_pkg::*;

	localparam int exp_latency = 9; // Accept edge to result edge.
	localparam int wait_limit  = 200;

	logic        clk;
	logic        rst_n;
	logic        load;
	weight_mat_t weights;
	logic        busy;
	logic        act_valid;
	act_vec_t    act;
	logic        result_valid;
	sum_vec_t    result;

	integer   seed = 58739;
	int       cycle = 0;
	int       accept_q [$]; // Cycle at which each vector is accepted.
	sum_vec_t last_result;
	int       mismatch_cnt = 0;
	int       missing_cnt = 0;
	int       timeout_cnt = 0;
	int       busy_cycles;

	`include "sa_model.svh"

	sa_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.load         (load),
		.weights      (weights),
		.busy         (busy),
		.act_valid    (act_valid),
		.act          (act),
		.result_valid (result_valid),
		.result       (result)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic act_vec_t random_vec();
		act_vec_t v;
		for (int i = 0; i < array_dim; i++) begin
			v[i] = data_t'($random(seed));
		end
		return v;
	endfunction

	function automatic weight_mat_t random_mat();
		weight_mat_t m;
		for (int i = 0; i < array_dim; i++) begin
			for (int j = 0; j < array_dim; j++) begin
				m[i][j] = weight_t'($random(seed));
			end
		end
		return m;
	endfunction

	// Leaves act_valid high; the next task call lowers it or sends again.
	task automatic send_vector(input act_vec_t a);
		@(posedge clk);
		act_valid <= 1'b1;
		act       <= a;
		model_push(a);
		accept_q.push_back(cycle + 1);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		act_valid <= 1'b0;
	endtask

	task automatic load_matrix(input weight_mat_t w, output int high_cycles);
		int waited;
		bit done;
		@(posedge clk);
		act_valid <= 1'b0;
		load      <= 1'b1;
		weights   <= w;
		model_set_matrix(w);
		@(posedge clk);
		load <= 1'b0;
		high_cycles = 0;
		waited = 0;
		done = 1'b0;
		while (!done && waited < wait_limit) begin
			@(posedge clk);
			waited++;
			if (busy) high_cycles++;
			else if (high_cycles > 0) done = 1'b1;
		end
		assert (done) else begin
			$display("Timed out waiting for the weight load to finish at %0t", $time);
			timeout_cnt++;
		end
	endtask

	task automatic drain_results();
		int waited;
		idle_cycle();
		waited = 0;
		while (model_pending() != 0 && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		assert (model_pending() == 0) else begin
			$display("Timed out waiting for %0d results at %0t", model_pending(), $time);
			timeout_cnt++;
		end
	endtask

	// Result monitor. Values read here were set on the previous edge.
	always @(posedge clk) begin : monitor
		sum_vec_t exp_s;
		int       acc_c;
		if (rst_n && result_valid) begin
			assert (model_pending() != 0) else begin
				$display("Result arrived at %0t with no vector outstanding", $time);
				missing_cnt++;
			end
			if (model_pending() != 0) begin
				exp_s = exp_q.pop_front();
				acc_c = accept_q.pop_front();
				last_result = result;
				assert (result == exp_s) else begin
					$display("Fail %0t: result %h, expected %h", $time, result, exp_s);
					mismatch_cnt++;
				end
				assert (cycle - acc_c == exp_latency) else begin
					$display("Fail %0t: latency %0d, expected %0d", $time, cycle - acc_c,
						exp_latency);
					mismatch_cnt++;
				end
			end
		end
	end

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		load      = 1'b0;
		weights   = '0;
		act_valid = 1'b0;
		act       = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		assert (!busy && !result_valid) else begin
			$display("Fail %0t: busy %b result_valid %b after reset", $time, busy, result_valid);
			mismatch_cnt++;
		end

		// No load yet, so every sum is zero.
		for (int n = 0; n < 4; n++) send_vector(random_vec());
		drain_results();

		// Idle load, then one vector.
		load_matrix(random_mat(), busy_cycles);
		assert (busy_cycles == 5) else begin
			$display("Fail %0t: busy for %0d cycles, expected 5", $time, busy_cycles);
			mismatch_cnt++;
		end
		send_vector(random_vec());
		drain_results();

		// Back to back.
		for (int n = 0; n < 40; n++) send_vector(random_vec());
		drain_results();

		// Load right behind vectors still in the pipeline.
		for (int n = 0; n < 6; n++) send_vector(random_vec());
		load_matrix(random_mat(), busy_cycles);
		assert (busy_cycles > 5) else begin
			$display("Fail %0t: busy for %0d cycles with vectors in flight", $time, busy_cycles);
			mismatch_cnt++;
		end
		assert (model_pending() == 0) else begin
			$display("Weight load finished while vectors were still in flight");
			missing_cnt++;
		end
		for (int n = 0; n < 8; n++) send_vector(random_vec());
		drain_results();

		// Random gaps.
		for (int n = 0; n < 80; n++) begin
			if ($random(seed) & 1) send_vector(random_vec());
			else idle_cycle();
		end
		drain_results();

		// Largest operands.
		load_matrix('1, busy_cycles);
		send_vector('1);
		drain_results();
		assert (last_result == {array_dim{acc_t'(260100)}}) else begin
			$display("Fail %0t: full scale result %h", $time, last_result);
			mismatch_cnt++;
		end

		repeat (12) @(posedge clk);
		assert (model_pending() == 0) else begin
			$display("%0d expected results never arrived", model_pending());
			missing_cnt += model_pending();
		end

		$display("Errors: %0d mismatches, %0d missing or extra results, %0d timeouts",
			mismatch_cnt, missing_cnt, timeout_cnt);
		if (mismatch_cnt + missing_cnt + timeout_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- src/sa_array.sv
`timescale 1ns/1ps

module sa_array (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    shift,
	input  sa_bus_pkg::act_vec_t    act_skewed,
	input  sa_bus_pkg::weight_row_t weight_row,
	output sa_bus_pkg::sum_vec_t    sums
);

	import sa_cfg_pkg::*;

	// Outputs of every cell, indexed [row][column].
	data_t   act_link [array_dim][array_dim];
	weight_t wt_link  [array_dim][array_dim];
	acc_t    psum     [array_dim][array_dim];

	for (genvar i = 0; i < array_dim; i++) begin : g_row
		for (genvar j = 0; j < array_dim; j++) begin : g_col
			data_t   pe_data_in;
			weight_t pe_weight_in;
			acc_t    pe_sum_in;

			// Left edge takes the skewed activations.
			if (j == 0) begin : g_left_edge
				assign pe_data_in = act_skewed[i];
			end else begin : g_left_link
				assign pe_data_in = act_link[i][j-1];
			end

			// Top edge takes the new weight row and starts each sum at zero.
			if (i == 0) begin : g_top_edge
				assign pe_weight_in = weight_row[j];
				assign pe_sum_in    = '0;
			end else begin : g_top_link
				assign pe_weight_in = wt_link[i-1][j];
				assign pe_sum_in    = psum[i-1][j];
			end

			sa_pe i_pe (
				.clk        (clk),
				.rst_n      (rst_n),
				.shift      (shift),
				.data_in    (pe_data_in),
				.weight_in  (pe_weight_in),
				.sum_in     (pe_sum_in),
				.data_out   (act_link[i][j]),
				.weight_out (wt_link[i][j]),
				.sum_out    (psum[i][j])
			);
		end
	end

	// Bottom row sums registered once more before deskew.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sums <= '0;
		end else begin
			for (int j = 0; j < array_dim; j++) begin
				sums[j] <= psum[array_dim-1][j];
			end
		end
	end

endmodule

//--- src/sa_bus_pkg.sv
package sa_bus_pkg;

	import sa_cfg_pkg::*;

	// Element i drives grid row i.
	typedef data_t [array_dim-1:0] act_vec_t;

	// Element j is the weight for column j.
	typedef weight_t [array_dim-1:0] weight_row_t;

	// Row i holds W[i]. After a load, cell (i,j) keeps W[i][j].
	typedef weight_row_t [array_dim-1:0] weight_mat_t;

	// Element j is the column j sum, sum over i of act[i] * W[i][j].
	typedef acc_t [array_dim-1:0] sum_vec_t;

endpackage

//--- src/sa_cfg_pkg.sv
package sa_cfg_pkg;

	// Grid side. The array is array_dim by array_dim cells.
	localparam int unsigned array_dim = 4;

	// Unsigned operand and sum widths.
	// 8x8 products summed over four rows stay well inside 24 bits.
	localparam int unsigned data_w = 8;
	localparam int unsigned acc_w  = 24;

	// One cycle into skew, array_dim through the grid, one bottom register,
	// then deskew and valid alignment. act_valid to result_valid.
	localparam int unsigned pipe_latency = 2 * array_dim + 1;

	// Counter sizes used by the weight loader.
	localparam int unsigned row_w = $clog2(array_dim);
	localparam int unsigned cnt_w = $clog2(pipe_latency + 1);

	typedef logic [data_w-1:0] data_t;   // Activation operand.
	typedef logic [data_w-1:0] weight_t; // Weight operand.
	typedef logic [acc_w-1:0]  acc_t;    // Partial or final sum.

	typedef logic [row_w-1:0] row_idx_t;    // Weight row being shifted in.
	typedef logic [cnt_w-1:0] flight_cnt_t; // Vectors inside the pipeline.

endpackage

//--- src/sa_deskew.sv
`timescale 1ns/1ps

module sa_deskew (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 vec_valid,
	input  sa_bus_pkg::sum_vec_t sums,
	output sa_bus_pkg::sum_vec_t result,
	output logic                 result_valid
);

	import sa_cfg_pkg::*;

	logic [2*array_dim-1:0] valid_q;

	// Column j leaves the grid j cycles after column 0.
	// It waits array_dim-1-j cycles so the whole vector lines up.
	for (genvar j = 0; j < array_dim; j++) begin : g_col
		if (j == array_dim - 1) begin : g_pass
			assign result[j] = sums[j]; // Last column is already late enough.
		end else begin : g_delay
			acc_t stage_q [array_dim-1-j];

			always_ff @(posedge clk) begin
				stage_q[0] <= sums[j];
				for (int k = 1; k < array_dim - 1 - j; k++) begin
					stage_q[k] <= stage_q[k-1];
				end
			end

			assign result[j] = stage_q[array_dim-2-j];
		end
	end

	// Valid from skew through the grid and deskew.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[2*array_dim-2:0], vec_valid};
		end
	end

	assign result_valid = valid_q[2*array_dim-1];

	// No vector can get through the pipeline faster than its latency.
	a_quiet_after_reset : assert property (@(posedge clk)
		$rose(rst_n) |-> !result_valid [*pipe_latency]);

endmodule

//--- src/sa_pe.sv
`timescale 1ns/1ps

module sa_pe (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                shift,
	input  sa_cfg_pkg::data_t   data_in,
	input  sa_cfg_pkg::weight_t weight_in,
	input  sa_cfg_pkg::acc_t    sum_in,
	output sa_cfg_pkg::data_t   data_out,
	output sa_cfg_pkg::weight_t weight_out,
	output sa_cfg_pkg::acc_t    sum_out
);

	import sa_cfg_pkg::*;

	weight_t weight_q;
	acc_t    product;

	// Both operands widened first so the product keeps all 16 bits.
	assign product = acc_t'(data_in) * acc_t'(weight_q);

	// Stationary weight.
	// On a shift the cell takes the weight from above and hands its old one down.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			weight_q <= '0;
		end else if (shift) begin
			weight_q <= weight_in;
		end
	end

	assign weight_out = weight_q;

	// Activation moves one cell right per cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_out <= '0;
		end else begin
			data_out <= data_in;
		end
	end

	// Partial sum moves one cell down per cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_out <= '0;
		end else begin
			sum_out <= sum_in + product;
		end
	end

endmodule

//--- src/sa_skew.sv
`timescale 1ns/1ps

module sa_skew (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 act_valid,
	input  sa_bus_pkg::act_vec_t act,
	output sa_bus_pkg::act_vec_t act_skewed,
	output logic                 vec_valid
);

	import sa_cfg_pkg::*;
	import sa_bus_pkg::*;

	act_vec_t act_in;

	// Zeros on idle cycles keep old operands out of the grid.
	assign act_in = act_valid ? act : '0;

	// Row i sits behind i+1 registers so it meets the sum coming down.
	for (genvar i = 0; i < array_dim; i++) begin : g_row
		data_t stage_q [i+1];

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				for (int k = 0; k <= i; k++) begin
					stage_q[k] <= '0;
				end
			end else begin
				stage_q[0] <= act_in[i];
				for (int k = 1; k <= i; k++) begin
					stage_q[k] <= stage_q[k-1];
				end
			end
		end

		assign act_skewed[i] = stage_q[i];
	end

	// Aligned with row 0.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vec_valid <= 1'b0;
		end else begin
			vec_valid <= act_valid;
		end
	end

endmodule

//--- src/sa_top.sv
`timescale 1ns/1ps

module sa_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load,
	input  sa_bus_pkg::weight_mat_t weights,
	output logic                    busy,
	input  logic                    act_valid,
	input  sa_bus_pkg::act_vec_t    act,
	output logic                    result_valid,
	output sa_bus_pkg::sum_vec_t    result
);

	import sa_cfg_pkg::*;
	import sa_bus_pkg::*;

	logic        shift;
	weight_row_t weight_row;
	act_vec_t    act_skewed;
	logic        vec_valid;
	sum_vec_t    sums;

	sa_weight_loader i_loader (
		.clk          (clk),
		.rst_n        (rst_n),
		.load         (load),
		.weights      (weights),
		.act_valid    (act_valid),
		.result_valid (result_valid),
		.shift        (shift),
		.weight_row   (weight_row),
		.busy         (busy)
	);

	sa_skew i_skew (
		.clk        (clk),
		.rst_n      (rst_n),
		.act_valid  (act_valid),
		.act        (act),
		.act_skewed (act_skewed),
		.vec_valid  (vec_valid)
	);

	sa_array i_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.shift      (shift),
		.act_skewed (act_skewed),
		.weight_row (weight_row),
		.sums       (sums)
	);

	sa_deskew i_deskew (
		.clk          (clk),
		.rst_n        (rst_n),
		.vec_valid    (vec_valid),
		.sums         (sums),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

//--- src/sa_weight_loader.sv
`timescale 1ns/1ps

module sa_weight_loader (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load,
	input  sa_bus_pkg::weight_mat_t weights,
	input  logic                    act_valid,
	input  logic                    result_valid,
	output logic                    shift,
	output sa_bus_pkg::weight_row_t weight_row,
	output logic                    busy
);

	import sa_cfg_pkg::*;
	import sa_bus_pkg::*;

	typedef enum logic [1:0] {
		idle,
		drain,
		shift_rows
	} state_t;

	state_t      state;
	weight_mat_t weights_q;
	flight_cnt_t in_flight;
	row_idx_t    row_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= idle;
			row_idx <= row_idx_t'(array_dim - 1);
		end else begin
			case (state)
				idle: begin
					if (load) begin
						state <= drain;
					end
				end
				drain: begin
					// Old vectors must leave before the weights change under them.
					if (in_flight == '0) begin
						state <= shift_rows;
					end
				end
				shift_rows: begin
					if (row_idx == '0) begin
						state   <= idle;
						row_idx <= row_idx_t'(array_dim - 1);
					end else begin
						row_idx <= row_idx - 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Matrix held for the whole load. A load while busy is dropped.
	always_ff @(posedge clk) begin
		if (state == idle && load) begin
			weights_q <= weights;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_flight <= '0;
		end else begin
			case ({act_valid, result_valid})
				2'b10:   in_flight <= in_flight + 1'b1;
				2'b01:   in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
		end
	end

	assign busy       = (state != idle);
	assign shift      = (state == shift_rows);
	assign weight_row = weights_q[row_idx]; // Last row goes in first.

	a_no_act_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !act_valid);

	// A result can only come back for a vector that was counted going in.
	a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
		(result_valid && !act_valid) |-> (in_flight != '0));

endmodule
